/* hw/mbIsaPkg.sv */
package mbIsaPkg;

   localparam int WORD_W = 32;
   localparam int REG_W  = 5;
   localparam int OPC_W  = 6;
   localparam int IMM_W  = 16;
   localparam int ALT_W  = 11;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  regIdx_t;
   typedef logic [OPC_W-1:0]  opcode_t;
   typedef logic [IMM_W-1:0]  imm_t;
   typedef logic [ALT_W-1:0]  alt_t;

   // Instruction fields, from the top bit down
   localparam int OPC_LSB      = 26;
   localparam int RD_LSB       = 21;
   localparam int RA_LSB       = 16;
   localparam int RB_LSB       = 11;
   localparam int ALT_LSB      = 0;
   localparam int IMM_LSB      = 0;
   localparam int IMM_FORM_BIT = 3;  // Opcode bit that selects the immediate form
   localparam int SFT_LSB      = 5;  // Shift kind sits in function bits 6:5

   localparam opcode_t OPC_ADD   = 6'o00;
   localparam opcode_t OPC_RSUB  = 6'o01;
   localparam opcode_t OPC_OR    = 6'o40;
   localparam opcode_t OPC_AND   = 6'o41;
   localparam opcode_t OPC_XOR   = 6'o42;
   localparam opcode_t OPC_SHIFT = 6'o44;
   localparam opcode_t OPC_LW    = 6'o62;
   localparam opcode_t OPC_SW    = 6'o66;
   localparam opcode_t OPC_LWI   = 6'o72;
   localparam opcode_t OPC_SWI   = 6'o76;

   // Logic function, the low two opcode bits of the logical group
   localparam logic [1:0] LOG_OR  = 2'b00;
   localparam logic [1:0] LOG_AND = 2'b01;
   localparam logic [1:0] LOG_XOR = 2'b10;

   localparam logic [1:0] SFT_SRA = 2'b00;  // Sign bit in
   localparam logic [1:0] SFT_SRC = 2'b01;  // Zero in, no carry here
   localparam logic [1:0] SFT_SRL = 2'b10;

endpackage

/* hw/mbPipePkg.sv */
package mbPipePkg;

   // Operand A and store data source
   typedef enum logic [1:0] {
      SRC_REG = 2'd0,
      SRC_FWD = 2'd1,   // Previous ALU result
      SRC_RAM = 2'd2    // Previous load data
   } opSel_t;

   // Operand B source
   typedef enum logic [1:0] {
      TGT_REG = 2'd0,
      TGT_FWD = 2'd1,
      TGT_RAM = 2'd2,
      TGT_IMM = 2'd3
   } tgtSel_t;

   // Destination kind; a load keeps DST_RAM even for r0 so the read still goes out
   typedef enum logic [1:0] {
      DST_REG  = 2'd0,
      DST_RAM  = 2'd2,
      DST_NONE = 2'd3
   } dstSel_t;

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_RSUB  = 3'd1,
      ALU_LOGIC = 3'd2,
      ALU_SHIFT = 3'd3
   } aluSel_t;

endpackage

/* hw/mbCtrl.sv */
`timescale 1ns/10ps

module mbCtrl (
   input  logic                gclk,
   input  logic                grst,
   input  logic                pipeEn,
   input  mbIsaPkg::word_t     dIreg,
   input  logic                dValid,
   output mbIsaPkg::regIdx_t   raIdx,
   output mbIsaPkg::regIdx_t   rbIdx,
   output mbIsaPkg::regIdx_t   rdIdx,
   output mbPipePkg::opSel_t   xSrcSel,
   output mbPipePkg::opSel_t   xAltSel,
   output mbPipePkg::tgtSel_t  xTgtSel,
   output mbPipePkg::aluSel_t  xAluSel,
   output mbPipePkg::dstSel_t  xDst,
   output mbIsaPkg::regIdx_t   xRw,
   output mbIsaPkg::word_t     xImm,
   output logic [1:0]          xShiftKind,
   output logic                xIsStore
);

   mbIsaPkg::opcode_t  opc;
   mbIsaPkg::opcode_t  opcBase;
   mbIsaPkg::regIdx_t  rd;
   mbIsaPkg::regIdx_t  ra;
   mbIsaPkg::regIdx_t  rb;
   mbIsaPkg::alt_t     alt;
   mbIsaPkg::imm_t     imm;
   logic               isAdd, isRsub, isLogic, isShift, isLoad, isStore;
   logic               xWrites;
   logic               aFwdR, aFwdM, bFwdR, bFwdM, dFwdR, dFwdM;
   mbPipePkg::opSel_t  nSrc, nAlt;
   mbPipePkg::tgtSel_t nTgt;
   mbPipePkg::aluSel_t nAlu;
   mbPipePkg::dstSel_t nDst;
   logic [1:0]         nKind;

   assign opc = dIreg[mbIsaPkg::OPC_LSB +: mbIsaPkg::OPC_W];
   assign rd  = dIreg[mbIsaPkg::RD_LSB +: mbIsaPkg::REG_W];
   assign ra  = dIreg[mbIsaPkg::RA_LSB +: mbIsaPkg::REG_W];
   assign rb  = dIreg[mbIsaPkg::RB_LSB +: mbIsaPkg::REG_W];
   assign alt = dIreg[mbIsaPkg::ALT_LSB +: mbIsaPkg::ALT_W];
   assign imm = dIreg[mbIsaPkg::IMM_LSB +: mbIsaPkg::IMM_W];

   assign raIdx = ra;
   assign rbIdx = rb;
   assign rdIdx = rd;   // Store data port

   always_comb begin
      opcBase = opc;
      opcBase[mbIsaPkg::IMM_FORM_BIT] = 1'b0;  // Fold immediate forms onto register forms
   end

   assign isAdd   = (opcBase == mbIsaPkg::OPC_ADD);
   assign isRsub  = (opcBase == mbIsaPkg::OPC_RSUB);
   assign isLogic = (opcBase == mbIsaPkg::OPC_OR) || (opcBase == mbIsaPkg::OPC_AND) ||
                    (opcBase == mbIsaPkg::OPC_XOR);
   assign isShift = (opc == mbIsaPkg::OPC_SHIFT);
   assign isLoad  = (opc == mbIsaPkg::OPC_LW) || (opc == mbIsaPkg::OPC_LWI);
   assign isStore = (opc == mbIsaPkg::OPC_SW) || (opc == mbIsaPkg::OPC_SWI);

   // Hazards against the instruction now in execute, r0 never forwards
   assign xWrites = (xRw != '0);
   assign aFwdR = xWrites && (xRw == ra) && (xDst == mbPipePkg::DST_REG);
   assign aFwdM = xWrites && (xRw == ra) && (xDst == mbPipePkg::DST_RAM);
   assign bFwdR = xWrites && (xRw == rb) && (xDst == mbPipePkg::DST_REG);
   assign bFwdM = xWrites && (xRw == rb) && (xDst == mbPipePkg::DST_RAM);
   assign dFwdR = xWrites && (xRw == rd) && (xDst == mbPipePkg::DST_REG);
   assign dFwdM = xWrites && (xRw == rd) && (xDst == mbPipePkg::DST_RAM);

   assign nSrc = aFwdM ? mbPipePkg::SRC_RAM : aFwdR ? mbPipePkg::SRC_FWD : mbPipePkg::SRC_REG;
   assign nAlt = dFwdM ? mbPipePkg::SRC_RAM : dFwdR ? mbPipePkg::SRC_FWD : mbPipePkg::SRC_REG;
   assign nTgt = opc[mbIsaPkg::IMM_FORM_BIT] ? mbPipePkg::TGT_IMM :
                 bFwdM ? mbPipePkg::TGT_RAM :
                 bFwdR ? mbPipePkg::TGT_FWD : mbPipePkg::TGT_REG;

   assign nAlu = isShift ? mbPipePkg::ALU_SHIFT :
                 isLogic ? mbPipePkg::ALU_LOGIC :
                 isRsub  ? mbPipePkg::ALU_RSUB : mbPipePkg::ALU_ADD;  // Loads and stores add

   // Logical group reuses the field for its function
   assign nKind = isLogic ? opc[1:0] : alt[mbIsaPkg::SFT_LSB +: 2];

   always_comb begin
      if (!dValid || isStore) begin
         nDst = mbPipePkg::DST_NONE;  // Bubble or store
      end else if (isLoad) begin
         nDst = mbPipePkg::DST_RAM;
      end else if ((isAdd || isRsub || isLogic || isShift) && rd != '0) begin
         nDst = mbPipePkg::DST_REG;
      end else begin
         nDst = mbPipePkg::DST_NONE;
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         xSrcSel  <= mbPipePkg::SRC_REG;
         xAltSel  <= mbPipePkg::SRC_REG;
         xTgtSel  <= mbPipePkg::TGT_REG;
         xAluSel  <= mbPipePkg::ALU_ADD;
         xDst     <= mbPipePkg::DST_NONE;
         xRw      <= '0;
         xIsStore <= 1'b0;
      end else if (pipeEn) begin
         xSrcSel  <= nSrc;
         xAltSel  <= nAlt;
         xTgtSel  <= nTgt;
         xAluSel  <= nAlu;
         xDst     <= nDst;
         xRw      <= rd;
         xIsStore <= dValid && isStore;
      end
   end

   always_ff @(posedge gclk) begin
      if (pipeEn) begin
         xImm       <= {{(mbIsaPkg::WORD_W - mbIsaPkg::IMM_W){imm[mbIsaPkg::IMM_W-1]}}, imm};
         xShiftKind <= nKind;
      end
   end

endmodule

/* hw/mbRegFile.sv */
`timescale 1ns/10ps

module mbRegFile (
   input  logic              gclk,
   input  logic              grst,
   input  logic              pipeEn,
   input  mbIsaPkg::regIdx_t raIdx,
   input  mbIsaPkg::regIdx_t rbIdx,
   input  mbIsaPkg::regIdx_t rdIdx,
   output mbIsaPkg::word_t   raData,
   output mbIsaPkg::word_t   rbData,
   output mbIsaPkg::word_t   rdData,
   input  logic              wbValid,
   input  mbIsaPkg::regIdx_t wbReg,
   input  mbIsaPkg::word_t   wbData
);

   localparam int NUM_REGS = 2 ** mbIsaPkg::REG_W;

   mbIsaPkg::word_t regs [NUM_REGS];

   // Pending writeback reaches a read of the same entry, two instructions back
   function automatic mbIsaPkg::word_t readPort(input mbIsaPkg::regIdx_t idx);
      if (wbValid && wbReg == idx && idx != '0) begin
         return wbData;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge gclk) begin
      if (grst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wbValid && wbReg != '0) begin
         regs[wbReg] <= wbData;  // r0 stays zero
      end
   end

   always_ff @(posedge gclk) begin
      if (pipeEn) begin
         raData <= readPort(raIdx);
         rbData <= readPort(rbIdx);
         rdData <= readPort(rdIdx);
      end
   end

endmodule

/* hw/mbExec.sv */
`timescale 1ns/10ps

module mbExec (
   input  logic               gclk,
   input  logic               grst,
   input  logic               pipeEn,
   input  mbPipePkg::opSel_t  xSrcSel,
   input  mbPipePkg::opSel_t  xAltSel,
   input  mbPipePkg::tgtSel_t xTgtSel,
   input  mbPipePkg::aluSel_t xAluSel,
   input  mbPipePkg::dstSel_t xDst,
   input  mbIsaPkg::regIdx_t  xRw,
   input  mbIsaPkg::word_t    xImm,
   input  logic [1:0]         xShiftKind,
   input  logic               xIsStore,
   input  mbIsaPkg::word_t    raData,
   input  mbIsaPkg::word_t    rbData,
   input  mbIsaPkg::word_t    rdData,
   input  logic               loadDone,
   input  mbIsaPkg::word_t    loadData,
   output logic               memReq,
   output logic               memWrite,
   output mbIsaPkg::word_t    memAddr,
   output mbIsaPkg::word_t    memWdata,
   output logic               wbValid,
   output mbIsaPkg::regIdx_t  wbReg,
   output mbIsaPkg::word_t    wbData
);

   mbIsaPkg::word_t   opA, opB, storeData, aluRes;
   mbIsaPkg::word_t   ramData;   // Last loaded word
   mbIsaPkg::regIdx_t pendReg;   // Destination of the load in flight
   logic              isMem;

   assign isMem = (xDst == mbPipePkg::DST_RAM) || xIsStore;

   always_comb begin
      case (xSrcSel)
         mbPipePkg::SRC_FWD: opA = wbData;
         mbPipePkg::SRC_RAM: opA = ramData;
         default:            opA = raData;
      endcase
      case (xAltSel)
         mbPipePkg::SRC_FWD: storeData = wbData;
         mbPipePkg::SRC_RAM: storeData = ramData;
         default:            storeData = rdData;
      endcase
      case (xTgtSel)
         mbPipePkg::TGT_FWD: opB = wbData;
         mbPipePkg::TGT_RAM: opB = ramData;
         mbPipePkg::TGT_IMM: opB = xImm;
         default:            opB = rbData;
      endcase
   end

   always_comb begin
      case (xAluSel)
         mbPipePkg::ALU_RSUB: aluRes = opB - opA;
         mbPipePkg::ALU_LOGIC: begin
            case (xShiftKind)
               mbIsaPkg::LOG_AND: aluRes = opA & opB;
               mbIsaPkg::LOG_XOR: aluRes = opA ^ opB;
               default:           aluRes = opA | opB;
            endcase
         end
         mbPipePkg::ALU_SHIFT: begin
            case (xShiftKind)
               mbIsaPkg::SFT_SRA: aluRes = {opA[mbIsaPkg::WORD_W-1], opA[mbIsaPkg::WORD_W-1:1]};
               mbIsaPkg::SFT_SRC, mbIsaPkg::SFT_SRL: aluRes = {1'b0, opA[mbIsaPkg::WORD_W-1:1]};
               default:           aluRes = opA;
            endcase
         end
         default: aluRes = opA + opB;  // Also the load and store address
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         wbValid <= 1'b0;
         memReq  <= 1'b0;
      end else begin
         memReq <= pipeEn && isMem;  // Single-cycle pulse, busy drops pipeEn next
         if (pipeEn) begin
            wbValid <= (xDst == mbPipePkg::DST_REG);
         end else if (loadDone) begin
            wbValid <= (pendReg != '0);
         end else begin
            wbValid <= 1'b0;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (pipeEn) begin
         if (xDst == mbPipePkg::DST_REG) begin
            wbReg  <= xRw;
            wbData <= aluRes;
         end
         if (isMem) begin
            memAddr  <= aluRes;
            memWdata <= storeData;
            memWrite <= xIsStore;
            pendReg  <= xRw;
         end
      end else if (loadDone) begin
         wbReg   <= pendReg;
         wbData  <= loadData;
         ramData <= loadData;
      end
   end

endmodule

/* hw/mbDataBus.sv */
`timescale 1ns/10ps

module mbDataBus (
   input  logic            gclk,
   input  logic            grst,
   input  logic            memReq,
   input  logic            memWrite,
   input  mbIsaPkg::word_t memAddr,
   input  mbIsaPkg::word_t memWdata,
   output logic            memBusy,
   output logic            loadDone,
   output mbIsaPkg::word_t loadData,
   output logic            awValid,
   input  logic            awReady,
   output mbIsaPkg::word_t awAddr,
   output logic            wValid,
   input  logic            wReady,
   output mbIsaPkg::word_t wData,
   output logic [3:0]      wStrb,
   input  logic            bValid,
   output logic            bReady,
   input  logic [1:0]      bResp,
   output logic            arValid,
   input  logic            arReady,
   output mbIsaPkg::word_t arAddr,
   input  logic            rValid,
   output logic            rReady,
   input  mbIsaPkg::word_t rData,
   input  logic [1:0]      rResp
);

   typedef enum logic [2:0] {IDLE, WRITE, WRESP, READ, RDATA} busState_t;

   busState_t state;
   logic      awFire, wFire;

   assign awFire = awValid && awReady;
   assign wFire  = wValid && wReady;

   assign bReady   = (state == WRESP);
   assign rReady   = (state == RDATA);
   assign wStrb    = '1;  // Word accesses only
   assign memBusy  = memReq || (state != IDLE);
   assign loadDone = (state == RDATA) && rValid;
   assign loadData = rData;

   always_ff @(posedge gclk) begin
      if (grst) begin
         state   <= IDLE;
         awValid <= 1'b0;
         wValid  <= 1'b0;
         arValid <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (memReq && memWrite) begin
                  awValid <= 1'b1;
                  wValid  <= 1'b1;
                  state   <= WRITE;
               end else if (memReq) begin
                  arValid <= 1'b1;
                  state   <= READ;
               end
            end
            WRITE: begin
               // Each valid drops on its own ready and marks that channel done
               if (awFire) awValid <= 1'b0;
               if (wFire) wValid <= 1'b0;
               if ((awFire || !awValid) && (wFire || !wValid)) begin
                  state <= WRESP;
               end
            end
            WRESP: if (bValid) state <= IDLE;  // Response code not acted on
            READ: begin
               if (arReady) begin
                  arValid <= 1'b0;
                  state   <= RDATA;
               end
            end
            RDATA: if (rValid) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge gclk) begin
      if (state == IDLE && memReq) begin
         awAddr <= memAddr;
         arAddr <= memAddr;
         wData  <= memWdata;
      end
   end

endmodule

/* hw/mbCore.sv */
`timescale 1ns/10ps

module mbCore (
   input  logic              gclk,
   input  logic              grst,
   input  logic              instrValid,
   input  mbIsaPkg::word_t   instr,
   output logic              instrReady,
   output logic              awValid,
   input  logic              awReady,
   output mbIsaPkg::word_t   awAddr,
   output logic              wValid,
   input  logic              wReady,
   output mbIsaPkg::word_t   wData,
   output logic [3:0]        wStrb,
   input  logic              bValid,
   output logic              bReady,
   input  logic [1:0]        bResp,
   output logic              arValid,
   input  logic              arReady,
   output mbIsaPkg::word_t   arAddr,
   input  logic              rValid,
   output logic              rReady,
   input  mbIsaPkg::word_t   rData,
   input  logic [1:0]        rResp,
   output logic              wbValid,
   output mbIsaPkg::regIdx_t wbReg,
   output mbIsaPkg::word_t   wbData
);

   mbIsaPkg::word_t    dIreg;
   logic               dValid;
   logic               runEn;    // Low for the first cycle out of reset
   logic               pipeEn;
   logic               memBusy, memReq, memWrite, loadDone, xIsStore;
   mbIsaPkg::word_t    memAddr, memWdata, loadData, xImm;
   mbIsaPkg::word_t    raData, rbData, rdData;
   mbIsaPkg::regIdx_t  raIdx, rbIdx, rdIdx, xRw;
   mbPipePkg::opSel_t  xSrcSel, xAltSel;
   mbPipePkg::tgtSel_t xTgtSel;
   mbPipePkg::aluSel_t xAluSel;
   mbPipePkg::dstSel_t xDst;
   logic [1:0]         xShiftKind;

   assign pipeEn     = runEn && !memBusy;
   assign instrReady = pipeEn;

   always_ff @(posedge gclk) begin
      if (grst) begin
         runEn  <= 1'b0;
         dValid <= 1'b0;
      end else begin
         runEn <= 1'b1;
         if (pipeEn) dValid <= instrValid;  // No valid leaves a bubble in decode
      end
   end

   always_ff @(posedge gclk) begin
      if (pipeEn) dIreg <= instr;
   end

   mbCtrl ctrl (
      .gclk, .grst, .pipeEn, .dIreg, .dValid, .raIdx, .rbIdx, .rdIdx,
      .xSrcSel, .xAltSel, .xTgtSel, .xAluSel, .xDst, .xRw, .xImm, .xShiftKind, .xIsStore
   );

   mbRegFile regFile (
      .gclk, .grst, .pipeEn, .raIdx, .rbIdx, .rdIdx, .raData, .rbData, .rdData,
      .wbValid, .wbReg, .wbData
   );

   mbExec exec (
      .gclk, .grst, .pipeEn, .xSrcSel, .xAltSel, .xTgtSel, .xAluSel, .xDst, .xRw, .xImm,
      .xShiftKind, .xIsStore, .raData, .rbData, .rdData, .loadDone, .loadData,
      .memReq, .memWrite, .memAddr, .memWdata, .wbValid, .wbReg, .wbData
   );

   mbDataBus dataBus (
      .gclk, .grst, .memReq, .memWrite, .memAddr, .memWdata, .memBusy, .loadDone, .loadData,
      .awValid, .awReady, .awAddr, .wValid, .wReady, .wData, .wStrb,
      .bValid, .bReady, .bResp, .arValid, .arReady, .arAddr,
      .rValid, .rReady, .rData, .rResp
   );

endmodule

/* include/mbTbModel.svh */
`ifndef MB_TB_MODEL_SVH
`define MB_TB_MODEL_SVH

int                errors;
mbIsaPkg::word_t   modelRegs [32];
mbIsaPkg::word_t   modelMem [16];
mbIsaPkg::regIdx_t expRegQ [$];
mbIsaPkg::word_t   expDataQ [$];
int                expCycleQ [$];
bit                expTimedQ [$];   // Latency is checked only with the pipeline free
mbIsaPkg::word_t   expAddrQ [$];
mbIsaPkg::word_t   expWdataQ [$];
mbIsaPkg::word_t   expRaddrQ [$];
int                memPending;      // Loads and stores not yet finished on the bus

function automatic logic [31:0] lcgNext(inout logic [31:0] state);
   state = state * 32'd1664525 + 32'd1013904223;
   return state;
endfunction

// Upper bits of the LCG are the better ones
function automatic int randBelow(inout logic [31:0] state, input int limit);
   logic [31:0] r;
   r = lcgNext(state);
   return int'(r[31:16]) % limit;
endfunction

function automatic mbIsaPkg::word_t fillWord(input int idx);
   return 32'h5A000000 ^ (idx * 32'h00130507) ^ (idx << 20);
endfunction

task automatic checkValue(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
   if (expVal !== actVal) begin
      $display("FAIL %s expected %h actual %h", name, expVal, actVal);
      errors++;
   end
endtask

// Executes one accepted instruction in program order
task automatic runModel(input mbIsaPkg::word_t ins, input int cyc);
   logic [5:0]      opc;
   logic [5:0]      base;
   logic [4:0]      rd, ra, rb;
   mbIsaPkg::word_t a, b, res;
   bit              isMem;
   opc  = ins[31:26];
   rd   = ins[25:21];
   ra   = ins[20:16];
   rb   = ins[15:11];
   base = opc & 6'b110111;
   a    = modelRegs[ra];
   b    = opc[3] ? {{16{ins[15]}}, ins[15:0]} : modelRegs[rb];
   isMem = (opc == 6'o62) || (opc == 6'o72) || (opc == 6'o66) || (opc == 6'o76);
   case (base)
      6'o00:   res = a + b;
      6'o01:   res = b - a;
      6'o40:   res = a | b;
      6'o41:   res = a & b;
      6'o42:   res = a ^ b;
      6'o44:   res = (ins[6:5] == 2'b00) ? {a[31], a[31:1]} : {1'b0, a[31:1]};
      default: res = a + b;   // Memory address
   endcase
   if (opc == 6'o62 || opc == 6'o72) expRaddrQ.push_back(res);  // Read goes out even for r0
   if (opc == 6'o66 || opc == 6'o76) begin
      expAddrQ.push_back(res);
      expWdataQ.push_back(modelRegs[rd]);
      modelMem[res[5:2]] = modelRegs[rd];
   end else if (rd != 0) begin
      if (isMem) res = modelMem[res[5:2]];
      modelRegs[rd] = res;
      expRegQ.push_back(rd);
      expDataQ.push_back(res);
      expCycleQ.push_back(cyc);
      expTimedQ.push_back(!isMem && memPending == 0);
   end
   if (isMem) memPending++;
endtask

`endif

/* bench/mbCoreTb.sv */
`timescale 1ns/10ps

module mbCoreTb;

   localparam int NUM_INSTR = 400;
   localparam int LIMIT     = 20000;

   logic gclk, grst, instrValid, instrReady;
   mbIsaPkg::word_t instr, awAddr, wData, arAddr, rData, wbData;
   logic awValid, awReady, wValid, wReady, bValid, bReady, arValid, arReady, rValid, rReady;
   logic [3:0] wStrb;
   logic [1:0] bResp, rResp;
   logic wbValid;
   mbIsaPkg::regIdx_t wbReg;

   logic [31:0] stimState, axiState;
   int cycle, issued, accepted, timeout;
   mbIsaPkg::word_t respMem [16];
   int awDelay, wDelay, arDelay, bDelay, rDelay;
   bit gotAw, gotW, bPending, rPending;
   mbIsaPkg::word_t capAddr, capData, rdAddr;

   `include "mbTbModel.svh"

   mbCore uut (
      .gclk(gclk), .grst(grst), .instrValid(instrValid), .instr(instr), .instrReady(instrReady),
      .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
      .wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb),
      .bValid(bValid), .bReady(bReady), .bResp(bResp),
      .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
      .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
   );

   always #10 gclk = ~gclk;

   // Random instruction from the kept set, registers r0 to r7
   function automatic mbIsaPkg::word_t makeInstr();
      logic [5:0] opc;
      logic [4:0] rd, ra, rb;
      logic [15:0] low;
      int pick;
      pick = randBelow(stimState, 15);
      rd  = 5'(randBelow(stimState, 8));
      ra  = 5'(randBelow(stimState, 8));
      rb  = 5'(randBelow(stimState, 8));
      low = 16'(randBelow(stimState, 65536));
      case (pick)
         0: opc = 6'o00;
         1: opc = 6'o10;
         2: opc = 6'o01;
         3: opc = 6'o11;
         4: opc = 6'o40;
         5: opc = 6'o50;
         6: opc = 6'o41;
         7: opc = 6'o51;
         8: opc = 6'o42;
         9: opc = 6'o52;
         10: opc = 6'o44;
         11: opc = 6'o62;
         12: opc = 6'o72;
         13: opc = 6'o66;
         default: opc = 6'o76;
      endcase
      if (opc == 6'o44) begin
         rb  = '0;
         low = {9'd0, 2'(randBelow(stimState, 3)), 5'd0};  // Shift kind in bits 6:5
      end else if (opc == 6'o72 || opc == 6'o76) begin
         ra  = '0;
         low = 16'(randBelow(stimState, 16) * 4);  // Word inside the window
      end else if (opc == 6'o62 || opc == 6'o66) begin
         ra = '0;
      end
      if (!opc[3] && opc != 6'o44) low = '0;
      return {opc, rd, ra, low[15:11] | (opc[3] ? 5'd0 : rb), low[10:0]};
   endfunction

   always @(posedge gclk) begin
      cycle <= cycle + 1;
      if (grst) begin
         instrValid <= 1'b0;
      end else if (!instrValid || instrReady) begin
         if (issued >= NUM_INSTR || randBelow(stimState, 4) == 0) begin
            instrValid <= 1'b0;   // Idle cycle
         end else begin
            instrValid <= 1'b1;
            instr      <= makeInstr();
            issued     <= issued + 1;
         end
      end
   end

   // Scoreboard, sampled on the edge before any update
   always @(posedge gclk) begin
      if (!grst) begin
         if ((rValid && rReady) || (bValid && bReady)) begin
            memPending--;   // Access finished on the bus
         end
         if (wbValid) begin
            if (expRegQ.size() == 0) begin
               $display("Writeback to r%0d arrived with no writeback expected", wbReg);
               errors++;
            end else begin
               checkValue("wb reg", expRegQ.pop_front(), wbReg);
               checkValue("wb data", expDataQ.pop_front(), wbData);
               if (expTimedQ.pop_front()) begin
                  checkValue("alu latency", 3, cycle - expCycleQ[0]);  // High after edge n+2
               end
               void'(expCycleQ.pop_front());
            end
         end
         if (instrValid && instrReady) begin
            runModel(instr, cycle);
            accepted++;
         end
         if (arValid || awValid || wValid || rReady || bReady) begin
            checkValue("ready during access", 0, instrReady);
         end
      end
   end

   // AXI4-Lite memory with random handshake delays
   always @(posedge gclk) begin
      if (grst) begin
         awReady <= 1'b0;
         wReady  <= 1'b0;
         arReady <= 1'b0;
         bValid  <= 1'b0;
         rValid  <= 1'b0;
      end else begin
         if (awValid && awReady) begin
            awReady <= 1'b0;
            gotAw   = 1'b1;
            capAddr = awAddr;
            awDelay = randBelow(axiState, 4);
         end else if (awValid) begin
            if (awDelay == 0) awReady <= 1'b1;
            else awDelay--;
         end
         if (wValid && wReady) begin
            wReady  <= 1'b0;
            gotW    = 1'b1;
            capData = wData;
            checkValue("store strobe", 4'hF, wStrb);
            wDelay  = randBelow(axiState, 4);
         end else if (wValid) begin
            if (wDelay == 0) wReady <= 1'b1;
            else wDelay--;
         end
         if (gotAw && gotW) begin
            if (expAddrQ.size() == 0) begin
               $display("Store arrived on the bus with no store expected");
               errors++;
            end else begin
               checkValue("store addr", expAddrQ.pop_front(), capAddr);
               checkValue("store data", expWdataQ.pop_front(), capData);
            end
            respMem[capAddr[5:2]] = capData;
            gotAw    = 1'b0;
            gotW     = 1'b0;
            bPending = 1'b1;
            bDelay   = randBelow(axiState, 4);
         end
         if (bValid && bReady) begin
            bValid <= 1'b0;
         end else if (bPending) begin
            if (bDelay == 0) begin
               bValid   <= 1'b1;
               bPending = 1'b0;
            end else bDelay--;
         end
         if (arValid && arReady) begin
            if (expRaddrQ.size() == 0) begin
               $display("Load arrived on the bus with no load expected");
               errors++;
            end else begin
               checkValue("load addr", expRaddrQ.pop_front(), arAddr);
            end
            arReady  <= 1'b0;
            rdAddr   = arAddr;
            rPending = 1'b1;
            rDelay   = randBelow(axiState, 4);
            arDelay  = randBelow(axiState, 4);
         end else if (arValid) begin
            if (arDelay == 0) arReady <= 1'b1;
            else arDelay--;
         end
         if (rValid && rReady) begin
            rValid <= 1'b0;
         end else if (rPending) begin
            if (rDelay == 0) begin
               rValid   <= 1'b1;
               rData    <= respMem[rdAddr[5:2]];
               rPending = 1'b0;
            end else rDelay--;
         end
      end
   end

   initial begin
      gclk = 1'b0;
      grst = 1'b1;
      instrValid = 1'b0;
      instr = '0;
      {awReady, wReady, arReady, bValid, rValid} = '0;
      bResp = 2'b00;
      rResp = 2'b00;
      rData = '0;
      stimState = 32'd90;
      axiState  = 32'd90;
      {cycle, issued, accepted, errors} = '0;
      {awDelay, wDelay, arDelay, bDelay, rDelay} = '0;
      {gotAw, gotW, bPending, rPending} = '0;
      memPending = 0;
      for (int i = 0; i < 32; i++) modelRegs[i] = '0;
      for (int i = 0; i < 16; i++) begin
         modelMem[i] = fillWord(i);
         respMem[i]  = fillWord(i);
      end
      repeat (10) @(posedge gclk);
      grst <= 1'b0;
      @(posedge gclk);
      checkValue("reset wbValid", 0, wbValid);
      checkValue("reset awValid", 0, awValid);
      checkValue("reset wValid", 0, wValid);
      checkValue("reset arValid", 0, arValid);
      checkValue("reset bReady", 0, bReady);
      checkValue("reset rReady", 0, rReady);
      checkValue("reset instrReady", 0, instrReady);  // First cycle out of reset
      @(posedge gclk);
      checkValue("ready after reset", 1, instrReady);
      timeout = 0;
      while (accepted < NUM_INSTR && timeout < LIMIT) begin
         @(posedge gclk);
         timeout++;
      end
      if (timeout >= LIMIT) begin
         $display("Timed out waiting for the core to accept all instructions");
         errors++;
      end
      timeout = 0;
      while ((expRegQ.size() != 0 || expAddrQ.size() != 0 || expRaddrQ.size() != 0) &&
             timeout < 100) begin
         @(posedge gclk);
         timeout++;
      end
      if (timeout >= 100) begin
         $display("Timed out waiting for the last writebacks and stores");
         errors++;
      end
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+include
hw/mbIsaPkg.sv
hw/mbPipePkg.sv
hw/mbCtrl.sv
hw/mbRegFile.sv
hw/mbExec.sv
hw/mbDataBus.sv
hw/mbCore.sv
bench/mbCoreTb.sv

/* Bender.yml */
package:
  name: mbcore

sources:
  - hw/mbIsaPkg.sv
  - hw/mbPipePkg.sv
  - hw/mbCtrl.sv
  - hw/mbRegFile.sv
  - hw/mbExec.sv
  - hw/mbDataBus.sv
  - hw/mbCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mbCoreTb.sv
